// File: build.f
hw/vehicle_pkg.sv
hw/engine_cal_pkg.sv
hw/speed_dynamics.sv
hw/gear_selector.sv
hw/rpm_model.sv
hw/obd_monitor.sv
hw/vehicle_top.sv
sim/tb_vehicle.sv

// File: hw/engine_cal_pkg.sv
package engine_cal_pkg;

    // ========================================================================
    // pedal and speed limits
    // ========================================================================
    localparam logic [7:0]  ACCEL_DEAD_ZONE   = 8'd5;
    localparam logic [7:0]  REVERSE_MAX_SPEED = 8'd50;
    localparam logic [7:0]  TOP_SPEED         = 8'd250;
    localparam logic [13:0] REDLINE_CUT_RPM   = 14'd7900;

    // resistance grows sharply above the drag speed
    localparam logic [9:0]  RESIST_BASE = 10'd5;
    localparam logic [7:0]  DRAG_SPEED  = 8'd180;
    localparam logic [9:0]  DRAG_EXTRA  = 10'd100;

    // ========================================================================
    // braking
    // ========================================================================
    localparam logic [7:0]  ESS_SPEED      = 8'd50;
    localparam logic [7:0]  BRAKE_BAND_HI  = 8'd150;
    localparam logic [7:0]  BRAKE_BAND_MID = 8'd80;
    localparam logic [7:0]  HARD_STEP_HI   = 8'd2;
    localparam logic [7:0]  HARD_STEP_MID  = 8'd4;
    localparam logic [7:0]  HARD_STEP_LO   = 8'd8;
    localparam logic [7:0]  NORM_STEP_HI   = 8'd1;
    localparam logic [7:0]  NORM_STEP_MID  = 8'd2;
    localparam logic [7:0]  NORM_STEP_LO   = 8'd3;

    // ========================================================================
    // shift points and rpm
    // ========================================================================
    localparam logic [7:0]  DOWN_2_1   = 8'd20;
    localparam logic [7:0]  DOWN_3_2   = 8'd31;
    localparam logic [7:0]  DOWN_4_3   = 8'd50;
    localparam logic [7:0]  DOWN_5_4   = 8'd71;
    localparam logic [7:0]  DOWN_6_5   = 8'd105;
    localparam logic [7:0]  SHIFT_HYST = 8'd5;

    localparam logic [7:0]  RATIO_G1 = 8'd100;
    localparam logic [7:0]  RATIO_G2 = 8'd60;
    localparam logic [7:0]  RATIO_G3 = 8'd40;
    localparam logic [7:0]  RATIO_G4 = 8'd30;
    localparam logic [7:0]  RATIO_G5 = 8'd24;
    localparam logic [7:0]  RATIO_G6 = 8'd18;

    localparam logic [7:0]  PN_RPM_GAIN    = 8'd20;
    localparam logic [13:0] PN_REV_LIMIT   = 14'd4000;
    localparam logic [7:0]  DRIVE_RPM_GAIN = 8'd2;
    localparam logic [13:0] DRIVE_RPM_MAX  = 14'd8000;
    localparam logic [15:0] RPM_WRAP_LIMIT = 16'd10000;

    // ========================================================================
    // thermal and trip data
    // ========================================================================
    localparam logic [13:0] TEMP_HOT_RPM    = 14'd3500;
    localparam logic [7:0]  TEMP_NORMAL     = 8'd90;
    localparam logic [7:0]  TEMP_MAX        = 8'd130;
    localparam logic [15:0] MM_PER_KMH_SEC  = 16'd278;
    localparam logic [31:0] MM_PER_KM       = 32'd1000000;
    localparam logic [7:0]  FUEL_DRAIN_STEP = 8'd8;

    localparam logic [4:0]  HOT_RISE  = 5'd3;
    localparam logic [4:0]  WARM_RISE = 5'd10;
    localparam logic [4:0]  FAN_FALL  = 5'd15;
    localparam logic [4:0]  PARK_FALL = 5'd20;

endpackage

// File: hw/gear_selector.sv
`timescale 1ns/1ps

module gear_selector
    import vehicle_pkg::*;
    import engine_cal_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      tick_speed,
    input  lever_t    lever,
    input  accel_t    accel_eff,
    input  logic      brake_normal,
    input  logic      brake_hard,
    input  speed_t    speed,
    output gear_num_t gear_num
);

    // upshift points sit above the next downshift point
    localparam speed_t UP_1_2 = DOWN_2_1 + SHIFT_HYST;
    localparam speed_t UP_2_3 = DOWN_3_2 + SHIFT_HYST;
    localparam speed_t UP_3_4 = DOWN_4_3 + SHIFT_HYST;
    localparam speed_t UP_4_5 = DOWN_5_4 + SHIFT_HYST;
    localparam speed_t UP_5_6 = DOWN_6_5 + SHIFT_HYST;

    gear_num_t glide_gear;
    gear_num_t shift_gear;

    // pedal released so the gear follows speed directly
    always_comb begin
        if (speed < DOWN_2_1) begin
            glide_gear = 3'd1;
        end else if (speed < DOWN_3_2) begin
            glide_gear = 3'd2;
        end else if (speed < DOWN_4_3) begin
            glide_gear = 3'd3;
        end else if (speed < DOWN_5_4) begin
            glide_gear = 3'd4;
        end else if (speed < DOWN_6_5) begin
            glide_gear = 3'd5;
        end else begin
            glide_gear = 3'd6;
        end
    end

    // one step at a time from the current gear
    always_comb begin
        shift_gear = gear_num;
        case (gear_num)
            3'd1: if (speed >= UP_1_2) shift_gear = 3'd2;
            3'd2: begin
                if (speed < DOWN_2_1) shift_gear = 3'd1;
                else if (speed >= UP_2_3) shift_gear = 3'd3;
            end
            3'd3: begin
                if (speed < DOWN_3_2) shift_gear = 3'd2;
                else if (speed >= UP_3_4) shift_gear = 3'd4;
            end
            3'd4: begin
                if (speed < DOWN_4_3) shift_gear = 3'd3;
                else if (speed >= UP_4_5) shift_gear = 3'd5;
            end
            3'd5: begin
                if (speed < DOWN_5_4) shift_gear = 3'd4;
                else if (speed >= UP_5_6) shift_gear = 3'd6;
            end
            3'd6: if (speed < DOWN_6_5) shift_gear = 3'd5;
            default: shift_gear = 3'd1;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gear_num <= 3'd1;
        end else if (tick_speed && !brake_normal && !brake_hard) begin
            if (lever != LEVER_D) begin
                gear_num <= 3'd1;
            end else if (accel_eff == '0) begin
                gear_num <= glide_gear;
            end else begin
                gear_num <= shift_gear;
            end
        end
    end

endmodule

// File: hw/obd_monitor.sv
`timescale 1ns/1ps

module obd_monitor
    import vehicle_pkg::*;
    import engine_cal_pkg::*;
#(
    parameter level_t TEMP_AMBIENT = 8'd25
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   tick_1sec,
    input  logic   engine_on,
    input  speed_t speed,
    input  rpm_t   rpm,
    input  logic   fuel_drain,
    output level_t fuel,
    output level_t temp,
    output odo_t   odometer
);

    dist_acc_t  dist_acc;
    dist_acc_t  dist_sum;
    dwell_cnt_t temp_cnt;
    dwell_cnt_t temp_dwell;
    logic       temp_active;
    logic       temp_rise;
    logic       temp_hold;

    // ========================================================================
    // odometer
    // ========================================================================
    // one second at v km/h covers about v * 278 mm
    assign dist_sum = dist_acc + dist_acc_t'(speed) * dist_acc_t'(MM_PER_KMH_SEC);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dist_acc <= '0;
            odometer <= '0;
        end else if (tick_1sec && engine_on && speed != '0) begin
            if (dist_sum >= MM_PER_KM) begin
                odometer <= odometer + 32'd1;
                dist_acc <= dist_sum - MM_PER_KM;
            end else begin
                dist_acc <= dist_sum;
            end
        end
    end

    // ========================================================================
    // fuel
    // ========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fuel <= 8'd100;
        end else if (tick_1sec && fuel_drain) begin
            fuel <= (fuel >= FUEL_DRAIN_STEP) ? fuel - FUEL_DRAIN_STEP : '0;
        end
    end

    // ========================================================================
    // coolant temperature
    // ========================================================================
    // thermostat holds at normal temperature and the fan pulls it back down
    always_comb begin
        temp_dwell  = HOT_RISE;
        temp_active = 1'b0;
        temp_rise   = 1'b0;
        temp_hold   = 1'b0;
        if (engine_on && rpm > TEMP_HOT_RPM) begin
            temp_active = (temp < TEMP_MAX);
            temp_rise   = 1'b1;
        end else if (engine_on) begin
            if (temp < TEMP_NORMAL) begin
                temp_dwell  = WARM_RISE;
                temp_active = 1'b1;
                temp_rise   = 1'b1;
            end else if (temp > TEMP_NORMAL) begin
                temp_dwell  = FAN_FALL;
                temp_active = 1'b1;
            end else begin
                temp_hold = 1'b1;
            end
        end else begin
            // parked engine cools toward ambient
            temp_dwell  = PARK_FALL;
            temp_active = (temp > TEMP_AMBIENT);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            temp     <= TEMP_AMBIENT;
            temp_cnt <= '0;
        end else if (tick_1sec) begin
            if (temp_active) begin
                if (temp_cnt >= temp_dwell) begin
                    temp     <= temp_rise ? temp + 8'd1 : temp - 8'd1;
                    temp_cnt <= '0;
                end else begin
                    temp_cnt <= temp_cnt + 5'd1;
                end
            end else if (temp_hold) begin
                temp_cnt <= '0;
            end
        end
    end

endmodule

// File: hw/rpm_model.sv
`timescale 1ns/1ps

module rpm_model
    import vehicle_pkg::*;
    import engine_cal_pkg::*;
#(
    parameter rpm_t IDLE_RPM = 14'd800
) (
    input  logic      engine_on,
    input  lever_t    lever,
    input  accel_t    adc_accel,
    input  accel_t    accel_eff,
    input  speed_t    speed,
    input  gear_num_t gear_num,
    output rpm_t      rpm
);

    logic [15:0] pn_rpm;
    logic [15:0] wheel_rpm;
    logic [15:0] base_rpm;
    logic [15:0] drive_rpm;

    // free revving in park or neutral follows the raw pedal
    assign pn_rpm = 16'(IDLE_RPM) + 16'(adc_accel) * 16'(PN_RPM_GAIN);

    always_comb begin
        case (gear_num)
            3'd1:    wheel_rpm = 16'(speed) * 16'(RATIO_G1);
            3'd2:    wheel_rpm = 16'(speed) * 16'(RATIO_G2);
            3'd3:    wheel_rpm = 16'(speed) * 16'(RATIO_G3);
            3'd4:    wheel_rpm = 16'(speed) * 16'(RATIO_G4);
            3'd5:    wheel_rpm = 16'(speed) * 16'(RATIO_G5);
            3'd6:    wheel_rpm = 16'(speed) * 16'(RATIO_G6);
            default: wheel_rpm = 16'(IDLE_RPM);
        endcase
    end

    // engine never drops below idle while in gear
    always_comb begin
        base_rpm = wheel_rpm;
        if (base_rpm < 16'(IDLE_RPM)) base_rpm = 16'(IDLE_RPM);
        if (base_rpm > RPM_WRAP_LIMIT) base_rpm = 16'(IDLE_RPM);
    end

    // throttle load adds converter slip
    assign drive_rpm = base_rpm + 16'(accel_eff) * 16'(DRIVE_RPM_GAIN);

    always_comb begin
        if (!engine_on) begin
            rpm = '0;
        end else if (lever == LEVER_P || lever == LEVER_N) begin
            rpm = (pn_rpm > 16'(PN_REV_LIMIT)) ? PN_REV_LIMIT : rpm_t'(pn_rpm);
        end else begin
            rpm = (drive_rpm > 16'(DRIVE_RPM_MAX)) ? DRIVE_RPM_MAX : rpm_t'(drive_rpm);
        end
    end

endmodule

// File: hw/speed_dynamics.sv
`timescale 1ns/1ps

module speed_dynamics
    import vehicle_pkg::*;
    import engine_cal_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      tick_speed,
    input  logic      engine_on,
    input  lever_t    lever,
    input  accel_t    adc_accel,
    input  logic      brake_normal,
    input  logic      brake_hard,
    input  gear_num_t gear_num,
    input  rpm_t      rpm,
    output speed_t    speed,
    output accel_t    accel_eff,
    output logic      ess_trigger
);

    force_t     power;
    force_t     resistance;
    speed_t     brake_step;
    speed_t     braked_speed;
    dwell_cnt_t coast_cnt;
    dwell_cnt_t coast_dwell;
    logic       accel_blocked;

    // small pedal readings are ADC noise
    assign accel_eff = (adc_accel > ACCEL_DEAD_ZONE) ? adc_accel - ACCEL_DEAD_ZONE : '0;

    // reverse gets half the engine power
    always_comb begin
        if (engine_on && lever == LEVER_D) begin
            power = force_t'(accel_eff);
        end else if (engine_on && lever == LEVER_R) begin
            power = force_t'(accel_eff >> 1);
        end else begin
            power = '0;
        end
    end

    assign resistance = force_t'(speed) + RESIST_BASE
                      + ((speed >= DRAG_SPEED) ? DRAG_EXTRA : force_t'(0));

    // brakes bite harder at low speed
    always_comb begin
        if (speed > BRAKE_BAND_HI) begin
            brake_step = brake_hard ? HARD_STEP_HI : NORM_STEP_HI;
        end else if (speed > BRAKE_BAND_MID) begin
            brake_step = brake_hard ? HARD_STEP_MID : NORM_STEP_MID;
        end else begin
            brake_step = brake_hard ? HARD_STEP_LO : NORM_STEP_LO;
        end
    end

    assign braked_speed = (speed > brake_step) ? speed - brake_step : '0;

    assign accel_blocked = (lever == LEVER_R && speed >= REVERSE_MAX_SPEED)
                        || (speed >= TOP_SPEED)
                        || (rpm >= REDLINE_CUT_RPM);

    // ticks between 1 km/h steps while coasting
    always_comb begin
        case (gear_num)
            3'd1:    coast_dwell = 5'd1;
            3'd2:    coast_dwell = 5'd3;
            3'd3:    coast_dwell = 5'd6;
            3'd4:    coast_dwell = 5'd10;
            3'd5:    coast_dwell = (speed >= 8'd120) ? 5'd8 : 5'd15;
            3'd6: begin
                if (speed >= 8'd170) begin
                    coast_dwell = 5'd2;
                end else if (speed >= 8'd140) begin
                    coast_dwell = 5'd5;
                end else begin
                    coast_dwell = 5'd20;
                end
            end
            default: coast_dwell = 5'd0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            speed       <= '0;
            ess_trigger <= 1'b0;
            coast_cnt   <= '0;
        end else if (tick_speed) begin
            if (brake_hard) begin
                speed       <= braked_speed;
                ess_trigger <= (speed > ESS_SPEED);
            end else if (brake_normal) begin
                speed       <= braked_speed;
                ess_trigger <= 1'b0;
            end else begin
                ess_trigger <= 1'b0;
                if (power > resistance) begin
                    coast_cnt <= '0;
                    if (!accel_blocked) begin
                        speed <= speed + 8'd1;
                    end
                end else if (power < resistance) begin
                    if (speed != '0 && coast_cnt >= coast_dwell) begin
                        speed     <= speed - 8'd1;
                        coast_cnt <= '0;
                    end else begin
                        coast_cnt <= coast_cnt + 5'd1;
                    end
                end else begin
                    coast_cnt <= '0;
                end
            end
        end
    end

endmodule

// File: hw/vehicle_pkg.sv
package vehicle_pkg;

    // vehicle speed in km/h
    typedef logic [7:0] speed_t;

    // engine speed in rpm
    typedef logic [13:0] rpm_t;

    // raw or dead-zoned pedal position
    typedef logic [7:0] accel_t;

    // drive gear 1 to 6
    typedef logic [2:0] gear_num_t;

    // fuel percent or coolant temperature in degrees C
    typedef logic [7:0] level_t;

    // odometer in km and the running distance remainder in mm
    typedef logic [31:0] odo_t;
    typedef logic [31:0] dist_acc_t;

    // engine power and driving resistance share one scale
    typedef logic [9:0] force_t;

    // dwell counters for coast-down and coolant steps
    typedef logic [4:0] dwell_cnt_t;

    // gear lever encoding as read from the selector switch
    typedef enum logic [3:0] {
        LEVER_P = 4'd3,
        LEVER_R = 4'd6,
        LEVER_N = 4'd9,
        LEVER_D = 4'd12
    } lever_t;

endpackage

// File: hw/vehicle_top.sv
`timescale 1ns/1ps

module vehicle_top
    import vehicle_pkg::*;
#(
    parameter rpm_t   IDLE_RPM     = 14'd800,
    parameter level_t TEMP_AMBIENT = 8'd25
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      engine_on,
    input  logic      tick_1sec,
    input  logic      tick_speed,
    input  lever_t    lever,
    input  accel_t    adc_accel,
    input  logic      brake_normal,
    input  logic      brake_hard,
    input  logic      fuel_drain,
    output speed_t    speed,
    output rpm_t      rpm,
    output level_t    fuel,
    output level_t    temp,
    output odo_t      odometer,
    output logic      ess_trigger,
    output gear_num_t gear_num
);

    // pedal after the dead zone
    accel_t accel_eff;

    speed_dynamics speed_dynamics_i (
        .clk          (clk),
        .rst          (rst),
        .tick_speed   (tick_speed),
        .engine_on    (engine_on),
        .lever        (lever),
        .adc_accel    (adc_accel),
        .brake_normal (brake_normal),
        .brake_hard   (brake_hard),
        .gear_num     (gear_num),
        .rpm          (rpm),
        .speed        (speed),
        .accel_eff    (accel_eff),
        .ess_trigger  (ess_trigger)
    );

    gear_selector gear_selector_i (
        .clk          (clk),
        .rst          (rst),
        .tick_speed   (tick_speed),
        .lever        (lever),
        .accel_eff    (accel_eff),
        .brake_normal (brake_normal),
        .brake_hard   (brake_hard),
        .speed        (speed),
        .gear_num     (gear_num)
    );

    // rpm feeds back into the redline cut
    rpm_model #(
        .IDLE_RPM (IDLE_RPM)
    ) rpm_model_i (
        .engine_on (engine_on),
        .lever     (lever),
        .adc_accel (adc_accel),
        .accel_eff (accel_eff),
        .speed     (speed),
        .gear_num  (gear_num),
        .rpm       (rpm)
    );

    obd_monitor #(
        .TEMP_AMBIENT (TEMP_AMBIENT)
    ) obd_monitor_i (
        .clk        (clk),
        .rst        (rst),
        .tick_1sec  (tick_1sec),
        .engine_on  (engine_on),
        .speed      (speed),
        .rpm        (rpm),
        .fuel_drain (fuel_drain),
        .fuel       (fuel),
        .temp       (temp),
        .odometer   (odometer)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_vehicle -f build.f -o tb_vehicle \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/tb_vehicle)
echo "$out"
echo "$out" | grep -q "Everything OK" && exit 0 || exit 1

// File: sim/tb_vehicle.sv
`timescale 1ns/1ps

module tb_vehicle
    import vehicle_pkg::*;
    import engine_cal_pkg::*;
();

    // ticks summed over all phases at two clock cycles per tick
    localparam int TOTAL_TICKS  = 32 + 33 + 16 + 42 + 15 + 150 + 40 + 20 + 40 + 40 + 40;
    localparam int TICK_SPACING = 2;
    localparam int CYCLE_LIMIT  = TOTAL_TICKS * TICK_SPACING * 3 / 2 + 8;

    logic      clk;
    logic      rst;
    logic      engine_on;
    logic      tick_1sec;
    logic      tick_speed;
    lever_t    lever;
    accel_t    adc_accel;
    logic      brake_normal;
    logic      brake_hard;
    logic      fuel_drain;
    speed_t    speed;
    rpm_t      rpm;
    level_t    fuel;
    level_t    temp;
    odo_t      odometer;
    logic      ess_trigger;
    gear_num_t gear_num;

    string       test_name;
    logic [15:0] lfsr;
    logic        checking;
    int          cycle_cnt;

    // reference state
    int m_speed;
    int m_gear;
    int m_ess;
    int m_coast;
    int m_fuel;
    int m_temp;
    int m_temp_cnt;
    int m_odo;
    int m_acc;

    vehicle_top vehicle_top_i (
        .clk          (clk),
        .rst          (rst),
        .engine_on    (engine_on),
        .tick_1sec    (tick_1sec),
        .tick_speed   (tick_speed),
        .lever        (lever),
        .adc_accel    (adc_accel),
        .brake_normal (brake_normal),
        .brake_hard   (brake_hard),
        .fuel_drain   (fuel_drain),
        .speed        (speed),
        .rpm          (rpm),
        .fuel         (fuel),
        .temp         (temp),
        .odometer     (odometer),
        .ess_trigger  (ess_trigger),
        .gear_num     (gear_num)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ========================================================================
    // reference functions
    // ========================================================================
    function automatic int dead_zone(int a);
        return (a > 5) ? a - 5 : 0;
    endfunction

    function automatic int ref_rpm(logic on, lever_t lv, int a, int spd, int g);
        int r;
        int ratio;
        if (!on) return 0;
        if (lv == LEVER_P || lv == LEVER_N) begin
            r = 800 + 20 * a;
            return (r > 4000) ? 4000 : r;
        end
        case (g)
            1: ratio = 100;
            2: ratio = 60;
            3: ratio = 40;
            4: ratio = 30;
            5: ratio = 24;
            default: ratio = 18;
        endcase
        r = spd * ratio;
        if (r < 800) r = 800;
        if (r > 10000) r = 800;
        r = r + 2 * dead_zone(a);
        return (r > 8000) ? 8000 : r;
    endfunction

    function automatic int down_point(int g);
        case (g)
            2: return 20;
            3: return 31;
            4: return 50;
            5: return 71;
            default: return 105;
        endcase
    endfunction

    function automatic int glide_gear(int spd);
        int g;
        g = 1;
        for (int k = 2; k <= 6; k++) begin
            if (spd >= down_point(k)) g = k;
        end
        return g;
    endfunction

    function automatic int shift_gear(int g, int spd);
        if (g > 1 && spd < down_point(g)) return g - 1;
        if (g < 6 && spd >= down_point(g + 1) + 5) return g + 1;
        return g;
    endfunction

    function automatic int coast_dwell(int g, int spd);
        case (g)
            1: return 1;
            2: return 3;
            3: return 6;
            4: return 10;
            5: return (spd >= 120) ? 8 : 15;
            default: return (spd >= 170) ? 2 : ((spd >= 140) ? 5 : 20);
        endcase
    endfunction

    function automatic int brake_amount(logic hard, int spd);
        if (spd > 150) return hard ? 2 : 1;
        if (spd > 80) return hard ? 4 : 2;
        return hard ? 8 : 3;
    endfunction

    function automatic int next_fuel(int f);
        return (f >= 8) ? f - 8 : 0;
    endfunction

    // next speed, ess and coast counter from the old state
    task automatic step_speed(int r);
        int pwr;
        int res;
        int eff;
        int step;
        eff = dead_zone(int'(adc_accel));
        pwr = 0;
        if (engine_on && lever == LEVER_D) pwr = eff;
        if (engine_on && lever == LEVER_R) pwr = eff / 2;
        res = m_speed + 5 + ((m_speed >= 180) ? 100 : 0);
        if (brake_hard || brake_normal) begin
            step    = brake_amount(brake_hard, m_speed);
            m_ess   = (brake_hard && m_speed > 50) ? 1 : 0;
            m_speed = (m_speed > step) ? m_speed - step : 0;
        end else begin
            m_ess = 0;
            if (pwr > res) begin
                m_coast = 0;
                if (!((lever == LEVER_R && m_speed >= 50) || m_speed >= 250 || r >= 7900))
                    m_speed = m_speed + 1;
            end else if (pwr < res) begin
                if (m_speed != 0 && m_coast >= coast_dwell(m_gear, m_speed)) begin
                    m_speed = m_speed - 1;
                    m_coast = 0;
                end else begin
                    m_coast = (m_coast + 1) % 32;
                end
            end else begin
                m_coast = 0;
            end
        end
    endtask

    task automatic step_temp(int r);
        int dwell;
        logic active;
        logic rise;
        dwell  = 3;
        active = 1'b0;
        rise   = 1'b0;
        if (engine_on && r > 3500) begin
            active = (m_temp < 130);
            rise   = 1'b1;
        end else if (engine_on && m_temp == 90) begin
            m_temp_cnt = 0;
        end else if (engine_on) begin
            active = 1'b1;
            rise   = (m_temp < 90);
            dwell  = rise ? 10 : 15;
        end else begin
            active = (m_temp > 25);
            dwell  = 20;
        end
        if (active) begin
            if (m_temp_cnt >= dwell) begin
                m_temp     = rise ? m_temp + 1 : m_temp - 1;
                m_temp_cnt = 0;
            end else begin
                m_temp_cnt = m_temp_cnt + 1;
            end
        end
    endtask

    always @(posedge clk or posedge rst) begin
        int r;
        int g;
        if (rst) begin
            m_speed    = 0;
            m_gear     = 1;
            m_ess      = 0;
            m_coast    = 0;
            m_fuel     = 100;
            m_temp     = 25;
            m_temp_cnt = 0;
            m_odo      = 0;
            m_acc      = 0;
        end else begin
            r = ref_rpm(engine_on, lever, int'(adc_accel), m_speed, m_gear);
            if (tick_1sec) begin
                if (engine_on && m_speed > 0) begin
                    m_acc = m_acc + m_speed * 278;
                    if (m_acc >= 1000000) begin
                        m_odo = m_odo + 1;
                        m_acc = m_acc - 1000000;
                    end
                end
                if (fuel_drain) m_fuel = next_fuel(m_fuel);
                step_temp(r);
            end
            if (tick_speed) begin
                g = m_gear;
                if (!brake_normal && !brake_hard) begin
                    if (lever != LEVER_D) g = 1;
                    else if (dead_zone(int'(adc_accel)) == 0) g = glide_gear(m_speed);
                    else g = shift_gear(m_gear, m_speed);
                end
                step_speed(r);
                m_gear = g;
            end
        end
    end

    // ========================================================================
    // checking
    // ========================================================================
    task automatic check_value(string what, int expected, int actual);
        assert (expected == actual) else begin
            $display("MISMATCH %s %s expected %0d actual %0d", test_name, what,
                     expected, actual);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    always @(negedge clk) begin
        if (checking) begin
            check_value("speed", m_speed, int'(speed));
            check_value("gear_num", m_gear, int'(gear_num));
            check_value("ess_trigger", m_ess, int'(ess_trigger));
            check_value("rpm", ref_rpm(engine_on, lever, int'(adc_accel), m_speed, m_gear),
                        int'(rpm));
            check_value("fuel", m_fuel, int'(fuel));
            check_value("temp", m_temp, int'(temp));
            check_value("odometer", m_odo, int'(odometer));
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles in test %s", cycle_cnt, test_name);
            $display("Something failed");
            $fatal(1);
        end
    end

    // ========================================================================
    // stimulus
    // ========================================================================
    function automatic int draw_bits(int n);
        logic fb;
        int   v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    task automatic speed_ticks(int n);
        repeat (n) begin
            @(posedge clk);
            tick_speed <= 1'b1;
            @(posedge clk);
            tick_speed <= 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic sec_ticks(int n);
        repeat (n) begin
            @(posedge clk);
            tick_1sec <= 1'b1;
            @(posedge clk);
            tick_1sec <= 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic set_pedal(int a);
        @(posedge clk);
        adc_accel <= accel_t'(a);
        @(negedge clk);
    endtask

    initial begin
        int v;
        int n;
        lfsr         = 16'd13;
        checking     = 1'b0;
        cycle_cnt    = 0;
        test_name    = "reset";
        rst          = 1'b1;
        engine_on    = 1'b0;
        tick_1sec    = 1'b0;
        tick_speed   = 1'b0;
        lever        = LEVER_P;
        adc_accel    = '0;
        brake_normal = 1'b0;
        brake_hard   = 1'b0;
        fuel_drain   = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("speed", 0, int'(speed));
        check_value("rpm", 0, int'(rpm));
        check_value("fuel", 100, int'(fuel));
        check_value("temp", 25, int'(temp));
        check_value("odometer", 0, int'(odometer));
        check_value("ess_trigger", 0, int'(ess_trigger));
        check_value("gear_num", 1, int'(gear_num));
        checking = 1'b1;

        test_name = "idle_pn";
        @(posedge clk);
        engine_on <= 1'b1;
        for (int k = 0; k < 32; k++) begin
            @(posedge clk);
            lever <= (k < 16) ? LEVER_P : LEVER_N;
            v = draw_bits(8);
            adc_accel <= accel_t'(v);
            @(negedge clk);
            check_value("rpm", (800 + 20 * v > 4000) ? 4000 : 800 + 20 * v, int'(rpm));
        end

        // warm-up at idle, then high rpm, then parked
        test_name = "temp";
        set_pedal(0);
        sec_ticks(33);
        check_value("temp_warm", 25 + 3, int'(temp));
        set_pedal(200);
        sec_ticks(16);
        check_value("temp_hot", 28 + 4, int'(temp));
        @(posedge clk);
        engine_on <= 1'b0;
        sec_ticks(42);
        check_value("temp_park", 32 - 2, int'(temp));

        test_name = "fuel";
        @(posedge clk);
        fuel_drain <= 1'b1;
        for (int k = 1; k <= 15; k++) begin
            sec_ticks(1);
            check_value("fuel", (100 - 8 * k > 0) ? 100 - 8 * k : 0, int'(fuel));
        end
        @(posedge clk);
        fuel_drain <= 1'b0;

        test_name = "accel_d";
        @(posedge clk);
        engine_on <= 1'b1;
        lever     <= LEVER_D;
        for (int k = 0; k < 15; k++) begin
            v = draw_bits(8);
            set_pedal(200 + v % 56);
            speed_ticks(10);
        end

        // speed is held since no speed tick occurs
        test_name = "odometer";
        n = (1000000 + m_speed * 278 - 1) / (m_speed * 278);
        for (int k = 1; k <= 40; k++) begin
            sec_ticks(1);
            if (k == n - 1) check_value("odometer_before", 0, int'(odometer));
            if (k == n) check_value("odometer_step", 1, int'(odometer));
        end

        test_name = "brake";
        set_pedal(0);
        @(posedge clk);
        brake_normal <= 1'b1;
        speed_ticks(20);
        @(posedge clk);
        brake_normal <= 1'b0;
        brake_hard   <= 1'b1;
        for (int k = 0; k < 40 && m_speed > 50; k++) begin
            speed_ticks(1);
            check_value("ess_set", 1, int'(ess_trigger));
        end
        speed_ticks(1);
        check_value("ess_clear", 0, int'(ess_trigger));
        @(posedge clk);
        brake_hard   <= 1'b0;
        brake_normal <= 1'b1;
        for (int k = 0; k < 40 && m_speed >= 20; k++) begin
            speed_ticks(1);
        end
        @(posedge clk);
        brake_normal <= 1'b0;
        speed_ticks(1);
        check_value("glide_gear", 1, int'(gear_num));
        speed_ticks(39);

        $display("Everything OK");
        $finish;
    end

endmodule
